/* hv_settings.svh */
`ifndef HV_SETTINGS_SVH
`define HV_SETTINGS_SVH

// hypervector width in bits
`define HV_DIM 128
// width of one generator word
`define HV_WORD_W 32
// fill words per hypervector
`define HV_WORDS 4

// item memory depth and address width
`define HV_ITEMS 16
`define HV_ITEM_AW 4

// hardware threads, issued in rotation
`define HV_THREADS 5
`define HV_THREAD_W 3

// instruction word and rotate amount field
`define HV_INST_W 16
`define HV_SHIFT_W 7

// xorshift start value, reloaded by reset_item
`define HV_XORSHIFT_SEED 32'h92d68ca2

`endif

/* hv_pkg.sv */
`include "hv_settings.svh"

package hv_pkg;

    // one hypervector
    typedef logic [`HV_DIM-1:0] hv_vec_t;
    // one generator output word
    typedef logic [`HV_WORD_W-1:0] hv_word_t;
    typedef logic [`HV_ITEM_AW-1:0] item_addr_t;
    typedef logic [`HV_THREAD_W-1:0] thread_idx_t;

    // load form, msb set, item index in the low bits
    typedef struct packed {
        logic form;
        logic [`HV_INST_W-`HV_ITEM_AW-2:0] rsvd;
        item_addr_t addr;
    } hv_load_inst_t;

    // operate form, msb clear
    // bind_op makes r2 = r1 ^ t2
    typedef struct packed {
        logic form;
        logic permute;
        logic bind_op;
        logic store;
        logic keep;
        logic [`HV_INST_W-`HV_SHIFT_W-6:0] rsvd;
        logic [`HV_SHIFT_W-1:0] amount;
    } hv_op_inst_t;

    // same 16 bits, read by form bit
    typedef union packed {
        hv_load_inst_t ld;
        hv_op_inst_t op;
    } hv_inst_t;

endpackage

/* hv_item_memory.sv */
`timescale 1ns/1ps
`include "hv_settings.svh"

module hv_item_memory (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               gen,
    input  logic               reset_item,
    input  hv_pkg::item_addr_t item_memory_num,
    input  hv_pkg::item_addr_t rd_addr,
    output hv_pkg::hv_vec_t    rd_data,
    output logic               finish_gen
);

    localparam int WORD_CW = $clog2(`HV_WORDS);
    localparam logic [WORD_CW-1:0] LAST_WORD = WORD_CW'(`HV_WORDS - 1);

    // generator state and its three xorshift steps
    hv_pkg::hv_word_t   xs_state;
    hv_pkg::hv_word_t   xs_a;
    hv_pkg::hv_word_t   xs_b;
    hv_pkg::hv_word_t   xs_next;

    // fill word position inside the vector being built
    logic [WORD_CW-1:0] word_cnt;
    hv_pkg::hv_vec_t    asm_vec;
    logic               wr_pulse;
    hv_pkg::item_addr_t item_addr;

    hv_pkg::hv_vec_t    mem [`HV_ITEMS];

    // shifts 13 left, 17 right, 5 left
    always_comb begin
        xs_a    = xs_state ^ (xs_state << 13);
        xs_b    = xs_a ^ (xs_a >> 17);
        xs_next = xs_b ^ (xs_b << 5);
    end

    // one step per gen cycle
    // seed reload wins over advance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xs_state <= `HV_XORSHIFT_SEED;
        end else if (reset_item) begin
            xs_state <= `HV_XORSHIFT_SEED;
        end else if (gen) begin
            xs_state <= xs_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt <= '0;
            wr_pulse <= 1'b0;
        end else if (!gen) begin
            word_cnt <= '0;
            wr_pulse <= 1'b0;
        end else begin
            // wraps after the last word
            word_cnt <= (word_cnt == LAST_WORD) ? '0 : word_cnt + 1'b1;
            // vector complete, write it next cycle
            wr_pulse <= (word_cnt == LAST_WORD);
        end
    end

    // current state goes into slot word_cnt
    always_ff @(posedge clk) begin
        if (gen) begin
            asm_vec[word_cnt*`HV_WORD_W +: `HV_WORD_W] <= xs_state;
        end
    end

    // target item, one step per written vector
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            item_addr <= '0;
        end else if (!gen) begin
            item_addr <= '0;
        end else if (wr_pulse) begin
            item_addr <= item_addr + 1'b1;
        end
    end

    // storage, read address taken every cycle
    always_ff @(posedge clk) begin
        if (wr_pulse) begin
            mem[item_addr] <= asm_vec;
        end
        rd_data <= mem[rd_addr];
    end

    // high in the cycle the last requested item is written
    assign finish_gen = wr_pulse && (item_addr == item_memory_num);

endmodule

/* hv_inst_decode.sv */
`timescale 1ns/1ps
`include "hv_settings.svh"

module hv_inst_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  logic                   get_v,
    input  logic [`HV_INST_W-1:0]  get_d,
    output hv_pkg::hv_inst_t       inst,
    output logic                   inst_valid,
    output hv_pkg::thread_idx_t    thread
);

    localparam hv_pkg::thread_idx_t LAST_THREAD = `HV_THREAD_W'(`HV_THREADS - 1);

    // thread that the next strobe goes to
    hv_pkg::thread_idx_t next_thread;

    // word held for the execute cycle
    always_ff @(posedge clk) begin
        if (get_v) begin
            inst <= get_d;
        end
    end

    // execute strobe, one cycle after get_v
    // only while running
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= run & get_v;
        end
    end

    // rotation, back to 0 while stopped
    // idle cycles hold it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_thread <= '0;
        end else if (!run) begin
            next_thread <= '0;
        end else if (get_v) begin
            next_thread <= (next_thread == LAST_THREAD) ? '0 : next_thread + 1'b1;
        end
    end

    // thread tag travels with inst
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thread <= '0;
        end else if (run & get_v) begin
            thread <= next_thread;
        end
    end

endmodule

/* hv_thread_exec.sv */
`timescale 1ns/1ps
`include "hv_settings.svh"

module hv_thread_exec (
    input  logic                clk,
    input  logic                arst_n,
    input  hv_pkg::hv_inst_t    inst,
    input  logic                inst_valid,
    input  hv_pkg::thread_idx_t thread,
    input  hv_pkg::hv_vec_t     item_data,
    output logic                store_en,
    output hv_pkg::hv_vec_t     store_vec
);

    // per thread register contexts
    hv_pkg::hv_vec_t r1_bank [`HV_THREADS];
    hv_pkg::hv_vec_t r2_bank [`HV_THREADS];

    // context of the thread in flight
    hv_pkg::hv_vec_t r1_cur;
    hv_pkg::hv_vec_t r2_cur;
    // r2, rotated or not
    hv_pkg::hv_vec_t t2;
    hv_pkg::hv_vec_t r2_wdata;

    logic is_load;
    logic r1_we;
    logic r2_we;

    // contexts read directly, no prefetch
    assign r1_cur = r1_bank[thread];
    assign r2_cur = r2_bank[thread];

    // msb picks load or operate form
    assign is_load = inst.ld.form;

    // rotate left by amount
    // amount 0 leaves r2 as is, right shift by full width is zero
    always_comb begin
        if (inst.op.permute) begin
            t2 = (r2_cur << inst.op.amount) | (r2_cur >> (`HV_DIM - int'(inst.op.amount)));
        end else begin
            t2 = r2_cur;
        end
    end

    // keep copies t2 into r1
    assign r1_we = inst_valid & ~is_load & inst.op.keep;

    // r2 takes the item on a load, r1 ^ t2 on a bind
    // bind sees the old r1
    assign r2_we    = inst_valid & (is_load | inst.op.bind_op);
    assign r2_wdata = is_load ? item_data : (r1_cur ^ t2);

    // store only from the operate form
    assign store_en  = inst_valid & ~is_load & inst.op.store;
    assign store_vec = t2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `HV_THREADS; i++) begin
                r1_bank[i] <= '0;
            end
        end else if (r1_we) begin
            r1_bank[thread] <= t2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `HV_THREADS; i++) begin
                r2_bank[i] <= '0;
            end
        end else if (r2_we) begin
            r2_bank[thread] <= r2_wdata;
        end
    end

endmodule

/* hv_store_result.sv */
`timescale 1ns/1ps

module hv_store_result (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,
    input  logic            store_en,
    input  hv_pkg::hv_vec_t store_vec,
    output logic            store,
    output hv_pkg::hv_vec_t core_result
);

    // value captured with the pulse, held until the next one
    hv_pkg::hv_vec_t result_q;

    // one cycle pulse, nothing while stopped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store    <= 1'b0;
            result_q <= '0;
        end else if (!run) begin
            store    <= 1'b0;
            result_q <= '0;
        end else begin
            store <= store_en;
            if (store_en) begin
                result_q <= store_vec;
            end
        end
    end

    // zero outside the pulse
    assign core_result = store ? result_q : '0;

endmodule

/* hv_core_top.sv */
`timescale 1ns/1ps
`include "hv_settings.svh"

module hv_core_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    input  logic                  gen,
    input  logic                  reset_item,
    input  hv_pkg::item_addr_t    item_memory_num,
    input  logic                  get_v,
    input  logic [`HV_INST_W-1:0] get_d,
    output logic                  finish_gen,
    output logic                  store,
    output hv_pkg::hv_vec_t       core_result
);

    // decode to execute
    hv_pkg::hv_inst_t    inst;
    logic                inst_valid;
    hv_pkg::thread_idx_t thread;

    // item read, lines up with inst_valid
    hv_pkg::hv_vec_t     item_data;

    // execute to result
    logic                store_en;
    hv_pkg::hv_vec_t     store_vec;

    hv_inst_decode u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .get_v      (get_v),
        .get_d      (get_d),
        .inst       (inst),
        .inst_valid (inst_valid),
        .thread     (thread)
    );

    // item index sampled from get_d in the strobe cycle
    hv_item_memory u_item_mem (
        .clk             (clk),
        .arst_n          (arst_n),
        .gen             (gen),
        .reset_item      (reset_item),
        .item_memory_num (item_memory_num),
        .rd_addr         (get_d[`HV_ITEM_AW-1:0]),
        .rd_data         (item_data),
        .finish_gen      (finish_gen)
    );

    hv_thread_exec u_exec (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .thread     (thread),
        .item_data  (item_data),
        .store_en   (store_en),
        .store_vec  (store_vec)
    );

    hv_store_result u_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .store_en    (store_en),
        .store_vec   (store_vec),
        .store       (store),
        .core_result (core_result)
    );

endmodule

/* tb_hv_core.sv */
`timescale 1ns/1ps
`include "hv_settings.svh"

module tb_hv_core;

    localparam int MAX_ENT = 64;
    localparam int GEN_TIMEOUT = 200;

    logic                  clk;
    logic                  arst_n;
    logic                  run;
    logic                  gen;
    logic                  reset_item;
    hv_pkg::item_addr_t    item_memory_num;
    logic                  get_v;
    logic [`HV_INST_W-1:0] get_d;
    logic                  finish_gen;
    logic                  store;
    hv_pkg::hv_vec_t       core_result;

    // reference items and shadow thread contexts
    hv_pkg::hv_vec_t model_item [`HV_ITEMS];
    hv_pkg::hv_vec_t shadow_r1 [`HV_THREADS];
    hv_pkg::hv_vec_t shadow_r2 [`HV_THREADS];
    int              model_thread;

    // stimulus table, one row per cycle
    // expected store and value checked two cycles after the row
    string                 ent_name [MAX_ENT];
    logic                  ent_run [MAX_ENT];
    logic                  ent_v [MAX_ENT];
    logic [`HV_INST_W-1:0] ent_d [MAX_ENT];
    logic                  ent_store [MAX_ENT];
    hv_pkg::hv_vec_t       ent_vec [MAX_ENT];
    int                    n_ent;

    integer seed;

    hv_core_top dut0 (
        .clk             (clk),
        .arst_n          (arst_n),
        .run             (run),
        .gen             (gen),
        .reset_item      (reset_item),
        .item_memory_num (item_memory_num),
        .get_v           (get_v),
        .get_d           (get_d),
        .finish_gen      (finish_gen),
        .store           (store),
        .core_result     (core_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 13 left, 17 right, 5 left
    function automatic hv_pkg::hv_word_t xorshift_step(hv_pkg::hv_word_t x);
        hv_pkg::hv_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bit i moves to bit i + amt, wrapping
    function automatic hv_pkg::hv_vec_t rotate_left(hv_pkg::hv_vec_t v, int amt);
        hv_pkg::hv_vec_t r;
        for (int i = 0; i < `HV_DIM; i++) begin
            r[(i + amt) % `HV_DIM] = v[i];
        end
        return r;
    endfunction

    function automatic logic [`HV_INST_W-1:0] load_word(int item);
        hv_pkg::hv_inst_t w;
        w = '0;
        w.ld.form = 1'b1;
        w.ld.addr = hv_pkg::item_addr_t'(item);
        return w;
    endfunction

    function automatic logic [`HV_INST_W-1:0] op_word(logic perm, logic bnd, logic st,
                                                       logic kp, int amt);
        hv_pkg::hv_inst_t w;
        w = '0;
        w.op.permute = perm;
        w.op.bind_op = bnd;
        w.op.store = st;
        w.op.keep = kp;
        w.op.amount = amt[`HV_SHIFT_W-1:0];
        return w;
    endfunction

    // never zero, so every rotation really moves bits
    function automatic int rand_amount();
        return 1 + int'($unsigned($random(seed)) % (`HV_DIM - 1));
    endfunction

    function automatic int rand_item();
        return int'($unsigned($random(seed)) % `HV_ITEMS);
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic fail_value(input string name, input string what,
                              input hv_pkg::hv_vec_t exp, input hv_pkg::hv_vec_t act);
        $display("Error %s %s: expected %h, actual %h", name, what, exp, act);
        stop_run();
    endtask

    // word w of item i is step 4i+w of the generator
    task automatic build_items();
        hv_pkg::hv_word_t x;
        x = `HV_XORSHIFT_SEED;
        for (int i = 0; i < `HV_ITEMS; i++) begin
            for (int w = 0; w < `HV_WORDS; w++) begin
                model_item[i][w*`HV_WORD_W +: `HV_WORD_W] = x;
                x = xorshift_step(x);
            end
        end
    endtask

    // append one row and advance the shadow model in issue order
    task automatic add_entry(input string name, input logic r, input logic v,
                             input logic [`HV_INST_W-1:0] d);
        hv_pkg::hv_inst_t w;
        hv_pkg::hv_vec_t  t2;
        hv_pkg::hv_vec_t  old_r1;
        if (n_ent >= MAX_ENT) begin
            $display("stimulus table is full at row %s", name);
            stop_run();
        end
        w = d;
        ent_name[n_ent] = name;
        ent_run[n_ent] = r;
        ent_v[n_ent] = v;
        ent_d[n_ent] = d;
        ent_store[n_ent] = 1'b0;
        ent_vec[n_ent] = '0;
        // run low in the execute cycle swallows the pulse
        if (n_ent > 0 && !r) begin
            ent_store[n_ent-1] = 1'b0;
            ent_vec[n_ent-1] = '0;
        end
        if (!r) begin
            model_thread = 0;
        end else if (v) begin
            if (w.ld.form) begin
                shadow_r2[model_thread] = model_item[w.ld.addr];
            end else begin
                old_r1 = shadow_r1[model_thread];
                t2 = shadow_r2[model_thread];
                if (w.op.permute) begin
                    t2 = rotate_left(t2, int'(w.op.amount));
                end
                if (w.op.keep) begin
                    shadow_r1[model_thread] = t2;
                end
                // bind uses r1 from before this instruction
                if (w.op.bind_op) begin
                    shadow_r2[model_thread] = old_r1 ^ t2;
                end
                if (w.op.store) begin
                    ent_store[n_ent] = 1'b1;
                    ent_vec[n_ent] = t2;
                end
            end
            model_thread = (model_thread + 1) % `HV_THREADS;
        end
        n_ent++;
    endtask

    task automatic build_table();
        int base;
        n_ent = 0;
        model_thread = 0;
        for (int t = 0; t < `HV_THREADS; t++) begin
            shadow_r1[t] = '0;
            shadow_r2[t] = '0;
        end
        // a different item per thread, back to back
        base = rand_item();
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("load_a_t%0d", t), 1'b1, 1'b1, load_word(base + t));
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("store_a_t%0d", t), 1'b1, 1'b1, op_word(0, 0, 1, 0, 0));
        end
        // rotated store, r2 itself unchanged
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("store_rot_t%0d", t), 1'b1, 1'b1,
                      op_word(1, 0, 1, 0, rand_amount()));
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("store_again_t%0d", t), 1'b1, 1'b1, op_word(0, 0, 1, 0, 0));
        end
        add_entry("idle_a", 1'b1, 1'b0, '0);
        // r1 from rotated r2, nothing stored
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("keep_t%0d", t), 1'b1, 1'b1,
                      op_word(1, 0, 0, 1, rand_amount()));
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("load_b_t%0d", t), 1'b1, 1'b1, load_word(rand_item()));
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("bind_t%0d", t), 1'b1, 1'b1,
                      op_word(1, 1, 0, 0, rand_amount()));
        end
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("store_bind_t%0d", t), 1'b1, 1'b1, op_word(0, 0, 1, 0, 0));
        end
        // partial round, the last store cut off by the stop
        add_entry("store_part_t0", 1'b1, 1'b1, op_word(0, 0, 1, 0, 0));
        add_entry("store_part_t1", 1'b1, 1'b1, op_word(0, 0, 1, 0, 0));
        for (int k = 0; k < 3; k++) begin
            add_entry($sformatf("halted_%0d", k), 1'b0, 1'b1, op_word(0, 0, 1, 0, 0));
        end
        add_entry("idle_c", 1'b1, 1'b0, '0);
        // rotation restarts at thread 0
        for (int t = 0; t < `HV_THREADS; t++) begin
            add_entry($sformatf("store_resume_t%0d", t), 1'b1, 1'b1, op_word(0, 0, 1, 0, 0));
        end
        add_entry("idle_d", 1'b1, 1'b0, '0);
        add_entry("idle_e", 1'b1, 1'b0, '0);
    endtask

    task automatic check_row(input int i);
        assert (store === ent_store[i]) else begin
            fail_value(ent_name[i], "store", {{(`HV_DIM-1){1'b0}}, ent_store[i]},
                       {{(`HV_DIM-1){1'b0}}, store});
        end
        assert (core_result === ent_vec[i]) else begin
            fail_value(ent_name[i], "core_result", ent_vec[i], core_result);
        end
    endtask

    initial begin
        int cycles;
        int finish_cnt;
        seed = 32'h8c28;
        arst_n = 1'b0;
        run = 1'b0;
        gen = 1'b0;
        reset_item = 1'b0;
        item_memory_num = '0;
        get_v = 1'b0;
        get_d = '0;
        build_items();
        build_table();

        for (cycles = 0; cycles < 16; cycles++) begin
            @(posedge clk);
        end
        #1;
        arst_n = 1'b1;

        // reload the seed, then fill all items
        @(posedge clk);
        #1;
        reset_item = 1'b1;
        item_memory_num = hv_pkg::item_addr_t'(`HV_ITEMS - 1);
        @(posedge clk);
        #1;
        reset_item = 1'b0;
        gen = 1'b1;
        finish_cnt = 0;
        cycles = 0;
        while (finish_cnt == 0 && cycles < GEN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (!store) else begin
                fail_value("gen_fill", "store", '0, {{(`HV_DIM-1){1'b0}}, store});
            end
            if (finish_gen) begin
                finish_cnt++;
            end
        end
        if (finish_cnt == 0) begin
            $display("finish_gen did not rise within %0d cycles of generation", GEN_TIMEOUT);
            stop_run();
        end
        gen = 1'b0;
        // no second finish pulse once gen is low
        for (cycles = 0; cycles < 8; cycles++) begin
            @(posedge clk);
            #1;
            assert (!finish_gen && !store) else begin
                $display("finish_gen or store went high after generation ended");
                stop_run();
            end
        end
        run = 1'b1;

        // drive row i, check row i-2 in the same step
        for (int i = 0; i < n_ent + 2; i++) begin
            @(posedge clk);
            #1;
            if (i >= 2) begin
                check_row(i - 2);
            end
            if (i < n_ent) begin
                run = ent_run[i];
                get_v = ent_v[i];
                get_d = ent_d[i];
            end else begin
                run = 1'b1;
                get_v = 1'b0;
                get_d = '0;
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
hv_pkg.sv
hv_item_memory.sv
hv_inst_decode.sv
hv_thread_exec.sv
hv_store_result.sv
hv_core_top.sv
tb_hv_core.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_hv_core \
    --Mdir obj_dir -o sim_hv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_hv_core 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
